/* src/lce_consts.svh */
`ifndef LCE_CONSTS_SVH
`define LCE_CONSTS_SVH

// physical address and data word
`define LCE_PADDR_WIDTH 22
`define LCE_DATA_WIDTH 64

// one word per way in a block
`define LCE_WAYS 8
`define LCE_WAY_ID_WIDTH 3

// byte offset plus word offset
`define LCE_BLOCK_OFFSET_WIDTH 6

// coherence directories and local engines
`define LCE_NUM_CCE 4
`define LCE_CCE_ID_WIDTH 2
`define LCE_LCE_ID_WIDTH 2

`endif

/* src/lce_msg_pkg.sv */
`include "lce_consts.svh"

package lce_msg_pkg;

  typedef enum logic {
    e_lce_req_rd = 1'b0,
    e_lce_req_wr = 1'b1
  } lce_req_type_e;

  typedef enum logic {
    e_lce_req_cacheable     = 1'b0,
    e_lce_req_non_cacheable = 1'b1
  } lce_cacheable_e;

  // uncached access size, byte up to double word
  typedef enum logic [1:0] {
    e_nc_size_1 = 2'd0,
    e_nc_size_2 = 2'd1,
    e_nc_size_4 = 2'd2,
    e_nc_size_8 = 2'd3
  } lce_nc_size_e;

  typedef struct packed {
    logic [`LCE_CCE_ID_WIDTH-1:0] dst_id;
    logic [`LCE_LCE_ID_WIDTH-1:0] src_id;
    lce_req_type_e                msg_type;
    lce_cacheable_e               non_cacheable;
    lce_nc_size_e                 nc_size;
    logic [`LCE_WAY_ID_WIDTH-1:0] lru_way_id;
    logic                         lru_dirty;
    logic [`LCE_PADDR_WIDTH-1:0]  addr;
    logic [`LCE_DATA_WIDTH-1:0]   data;
  } lce_req_s;

  typedef enum logic {
    e_lce_resp_tr_ack  = 1'b0,
    e_lce_resp_coh_ack = 1'b1
  } lce_resp_type_e;

  typedef struct packed {
    logic [`LCE_CCE_ID_WIDTH-1:0] dst_id;
    logic [`LCE_LCE_ID_WIDTH-1:0] src_id;
    lce_resp_type_e               msg_type;
    logic [`LCE_PADDR_WIDTH-1:0]  addr;
  } lce_resp_s;

  typedef enum logic [2:0] {
    e_lce_cmd_set_tag        = 3'd0,
    e_lce_cmd_set_tag_wakeup = 3'd1,
    e_lce_cmd_data           = 3'd2,
    e_lce_cmd_transfer       = 3'd3,
    e_lce_cmd_uc_data        = 3'd4
  } lce_cmd_type_e;

  typedef struct packed {
    lce_cmd_type_e                msg_type;
    logic [`LCE_WAY_ID_WIDTH-1:0] way_id;
    logic [`LCE_PADDR_WIDTH-1:0]  addr;
    logic [`LCE_DATA_WIDTH-1:0]   data;
  } lce_cmd_s;

endpackage

/* src/dcache_if_pkg.sv */
`include "lce_consts.svh"

package dcache_if_pkg;

  // miss report from the cache, held until cache_miss_o falls
  typedef struct packed {
    logic                         load_miss;
    logic                         store_miss;
    logic                         uncached_load;
    logic                         uncached_store;
    logic [`LCE_PADDR_WIDTH-1:0]  addr;
    logic [`LCE_WAY_ID_WIDTH-1:0] lru_way;
    logic [`LCE_WAYS-1:0]         dirty;
    logic [`LCE_DATA_WIDTH-1:0]   store_data;
    logic [1:0]                   size;
  } dcache_miss_s;

  // one block word written into the data array
  typedef struct packed {
    logic [`LCE_WAY_ID_WIDTH-1:0] way_id;
    logic [`LCE_PADDR_WIDTH-1:0]  addr;
    logic [`LCE_DATA_WIDTH-1:0]   data;
  } dcache_fill_s;

endpackage

/* src/lce_msg_queue.sv */
`timescale 1ns/1ps

module lce_msg_queue #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  payload_t   mem_r [2];
  // extra top bit tells full from empty
  logic [1:0] wr_ptr_r, rd_ptr_r;
  logic       empty, full, push, pop;

  assign empty   = (wr_ptr_r == rd_ptr_r);
  assign full    = (wr_ptr_r[1] != rd_ptr_r[1]) && (wr_ptr_r[0] == rd_ptr_r[0]);
  assign ready_o = ~full;
  assign v_o     = ~empty;
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_r[rd_ptr_r[0]];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= 2'b00;
      rd_ptr_r <= 2'b00;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 2'd1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r[0]] <= data_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

/* src/dcache_lce_req.sv */
`timescale 1ns/1ps
`include "lce_consts.svh"

module dcache_lce_req
  import lce_msg_pkg::*, dcache_if_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [`LCE_LCE_ID_WIDTH-1:0] lce_id_i,
  input  dcache_miss_s                 miss_i,
  output logic                         cache_miss_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  miss_addr_o,
  input  logic                         set_tag_received_i,
  input  logic                         set_tag_wakeup_received_i,
  input  logic                         cce_data_received_i,
  input  logic                         tr_data_received_i,
  input  logic                         uncached_data_received_i,
  output lce_req_s                     req_o,
  output logic                         req_v_o,
  input  logic                         req_ready_i,
  output lce_resp_s                    resp_o,
  output logic                         resp_v_o,
  input  logic                         resp_ready_i
);

  typedef enum logic [2:0] {
    e_idle,
    e_send_cached_req,
    e_send_uncached_load,
    e_sleep,
    e_send_tr_ack,
    e_send_coh_ack
  } req_state_e;

  req_state_e state_r, state_n;

  // captured miss payload
  logic [`LCE_PADDR_WIDTH-1:0]  addr_r, addr_n;
  logic                         load_not_store_r, load_not_store_n;
  logic [1:0]                   size_r, size_n;
  logic [`LCE_WAY_ID_WIDTH-1:0] lru_way_r, lru_way_n;
  logic                         lru_dirty_r, lru_dirty_n;
  logic                         lru_frozen_r, lru_frozen_n;

  // strobes seen while sleeping
  logic set_tag_r, set_tag_n, set_tag_any;
  logic cce_data_r, cce_data_n, cce_data_any;
  logic tr_data_r, tr_data_n, tr_data_any;

  assign set_tag_any  = set_tag_r | set_tag_received_i;
  assign cce_data_any = cce_data_r | cce_data_received_i;
  assign tr_data_any  = tr_data_r | tr_data_received_i;
  assign miss_addr_o  = addr_r;

  always_comb begin
    state_n          = state_r;
    addr_n           = addr_r;
    load_not_store_n = load_not_store_r;
    size_n           = size_r;
    lru_way_n        = lru_way_r;
    lru_dirty_n      = lru_dirty_r;
    lru_frozen_n     = lru_frozen_r;
    set_tag_n        = set_tag_r;
    cce_data_n       = cce_data_r;
    tr_data_n        = tr_data_r;

    cache_miss_o = 1'b0;
    req_v_o      = 1'b0;
    resp_v_o     = 1'b0;

    req_o.dst_id        = addr_r[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_CCE_ID_WIDTH];
    req_o.src_id        = lce_id_i;
    req_o.msg_type      = load_not_store_r ? e_lce_req_rd : e_lce_req_wr;
    req_o.non_cacheable = e_lce_req_cacheable;
    req_o.nc_size       = lce_nc_size_e'(size_r);
    // lru way follows the cache until frozen
    req_o.lru_way_id    = lru_frozen_r ? lru_way_r : miss_i.lru_way;
    req_o.lru_dirty     = lru_frozen_r ? lru_dirty_r : miss_i.dirty[miss_i.lru_way];
    req_o.addr          = addr_r;
    req_o.data          = '0;

    // ack toward the home directory of the miss
    resp_o.dst_id   = addr_r[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_CCE_ID_WIDTH];
    resp_o.src_id   = lce_id_i;
    resp_o.addr     = addr_r;
    resp_o.msg_type = e_lce_resp_tr_ack;

    unique case (state_r)
      e_idle: begin
        if (miss_i.load_miss | miss_i.store_miss) begin
          addr_n           = miss_i.addr;
          load_not_store_n = miss_i.load_miss;
          size_n           = miss_i.size;
          lru_frozen_n     = 1'b0;
          set_tag_n        = 1'b0;
          cce_data_n       = 1'b0;
          tr_data_n        = 1'b0;
          cache_miss_o     = 1'b1;
          state_n          = e_send_cached_req;
        end else if (miss_i.uncached_load) begin
          addr_n       = miss_i.addr;
          size_n       = miss_i.size;
          set_tag_n    = 1'b0;
          cce_data_n   = 1'b0;
          tr_data_n    = 1'b0;
          cache_miss_o = 1'b1;
          state_n      = e_send_uncached_load;
        end else if (miss_i.uncached_store) begin
          // goes out straight from the live request
          req_v_o             = 1'b1;
          req_o.dst_id        = miss_i.addr[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_CCE_ID_WIDTH];
          req_o.msg_type      = e_lce_req_wr;
          req_o.non_cacheable = e_lce_req_non_cacheable;
          req_o.nc_size       = lce_nc_size_e'(miss_i.size);
          req_o.lru_way_id    = '0;
          req_o.lru_dirty     = 1'b0;
          req_o.addr          = miss_i.addr;
          req_o.data          = miss_i.store_data;
          cache_miss_o        = ~req_ready_i;
        end
      end

      e_send_cached_req: begin
        cache_miss_o = 1'b1;
        req_v_o      = 1'b1;
        lru_frozen_n = 1'b1;
        lru_way_n    = req_o.lru_way_id;
        lru_dirty_n  = req_o.lru_dirty;
        if (req_ready_i) begin
          state_n = e_sleep;
        end
      end

      e_send_uncached_load: begin
        cache_miss_o        = 1'b1;
        req_v_o             = 1'b1;
        req_o.msg_type      = e_lce_req_rd;
        req_o.non_cacheable = e_lce_req_non_cacheable;
        req_o.lru_way_id    = '0;
        req_o.lru_dirty     = 1'b0;
        if (req_ready_i) begin
          state_n = e_sleep;
        end
      end

      e_sleep: begin
        cache_miss_o = 1'b1;
        set_tag_n    = set_tag_any;
        cce_data_n   = cce_data_any;
        tr_data_n    = tr_data_any;
        if (set_tag_wakeup_received_i | uncached_data_received_i) begin
          state_n = e_idle;
        end else if (set_tag_any & tr_data_any) begin
          state_n = e_send_tr_ack;
        end else if (set_tag_any & cce_data_any) begin
          state_n = e_send_coh_ack;
        end
      end

      e_send_tr_ack: begin
        cache_miss_o    = 1'b1;
        resp_v_o        = 1'b1;
        resp_o.msg_type = e_lce_resp_tr_ack;
        if (resp_ready_i) begin
          state_n = e_idle;
        end
      end

      e_send_coh_ack: begin
        cache_miss_o    = 1'b1;
        resp_v_o        = 1'b1;
        resp_o.msg_type = e_lce_resp_coh_ack;
        if (resp_ready_i) begin
          state_n = e_idle;
        end
      end

      default: begin
        state_n = e_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r      <= e_idle;
      lru_frozen_r <= 1'b0;
      set_tag_r    <= 1'b0;
      cce_data_r   <= 1'b0;
      tr_data_r    <= 1'b0;
    end else begin
      state_r      <= state_n;
      lru_frozen_r <= lru_frozen_n;
      set_tag_r    <= set_tag_n;
      cce_data_r   <= cce_data_n;
      tr_data_r    <= tr_data_n;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_r           <= addr_n;
    load_not_store_r <= load_not_store_n;
    size_r           <= size_n;
    lru_way_r        <= lru_way_n;
    lru_dirty_r      <= lru_dirty_n;
  end

  // the command side only answers an outstanding miss
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == e_idle) |-> !(set_tag_received_i | set_tag_wakeup_received_i
      | cce_data_received_i | tr_data_received_i | uncached_data_received_i));

  assert property (@(posedge clk_i) disable iff (reset_i)
    state_r inside {e_idle, e_send_cached_req, e_send_uncached_load,
                    e_sleep, e_send_tr_ack, e_send_coh_ack});

endmodule

/* src/dcache_lce_cmd.sv */
`timescale 1ns/1ps
`include "lce_consts.svh"

module dcache_lce_cmd
  import lce_msg_pkg::*, dcache_if_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  lce_cmd_s                     cmd_i,
  input  logic                         cmd_v_i,
  output logic                         cmd_ready_o,
  output logic                         set_tag_received_o,
  output logic                         set_tag_wakeup_received_o,
  output logic                         cce_data_received_o,
  output logic                         tr_data_received_o,
  output logic                         uncached_data_received_o,
  output dcache_fill_s                 fill_o,
  output logic                         fill_v_o,
  output logic                         tag_v_o,
  output logic [`LCE_WAY_ID_WIDTH-1:0] tag_way_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  tag_addr_o
);

  lce_cmd_s cmd_r;
  logic     cmd_v_r;

  // every command is consumed in one cycle
  assign cmd_ready_o = 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd_v_r <= 1'b0;
    end else begin
      cmd_v_r <= cmd_v_i & cmd_ready_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i) begin
      cmd_r <= cmd_i;
    end
  end

  // decode of the registered command
  always_comb begin
    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o       = 1'b0;
    tr_data_received_o        = 1'b0;
    uncached_data_received_o  = 1'b0;
    fill_v_o                  = 1'b0;
    tag_v_o                   = 1'b0;

    if (cmd_v_r) begin
      unique case (cmd_r.msg_type)
        e_lce_cmd_set_tag: begin
          set_tag_received_o = 1'b1;
          tag_v_o            = 1'b1;
        end
        e_lce_cmd_set_tag_wakeup: begin
          set_tag_wakeup_received_o = 1'b1;
          tag_v_o                   = 1'b1;
        end
        e_lce_cmd_data: begin
          cce_data_received_o = 1'b1;
          fill_v_o            = 1'b1;
        end
        e_lce_cmd_transfer: begin
          tr_data_received_o = 1'b1;
          fill_v_o           = 1'b1;
        end
        e_lce_cmd_uc_data: begin
          uncached_data_received_o = 1'b1;
          fill_v_o                 = 1'b1;
        end
        default: begin
          fill_v_o = 1'b0;
        end
      endcase
    end
  end

  assign fill_o.way_id = cmd_r.way_id;
  assign fill_o.addr   = cmd_r.addr;
  assign fill_o.data   = cmd_r.data;
  assign tag_way_o     = cmd_r.way_id;
  assign tag_addr_o    = cmd_r.addr;

  assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> cmd_i.msg_type inside {e_lce_cmd_set_tag, e_lce_cmd_set_tag_wakeup,
      e_lce_cmd_data, e_lce_cmd_transfer, e_lce_cmd_uc_data});

endmodule

/* src/dcache_lce.sv */
`timescale 1ns/1ps
`include "lce_consts.svh"

module dcache_lce
  import lce_msg_pkg::*, dcache_if_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [`LCE_LCE_ID_WIDTH-1:0] lce_id_i,
  input  dcache_miss_s                 miss_i,
  output logic                         cache_miss_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  miss_addr_o,
  input  lce_cmd_s                     lce_cmd_i,
  input  logic                         lce_cmd_v_i,
  output logic                         lce_cmd_ready_o,
  output lce_req_s                     lce_req_o,
  output logic                         lce_req_v_o,
  input  logic                         lce_req_ready_i,
  output lce_resp_s                    lce_resp_o,
  output logic                         lce_resp_v_o,
  input  logic                         lce_resp_yumi_i,
  output dcache_fill_s                 fill_o,
  output logic                         fill_v_o,
  output logic                         tag_v_o,
  output logic [`LCE_WAY_ID_WIDTH-1:0] tag_way_o,
  output logic [`LCE_PADDR_WIDTH-1:0]  tag_addr_o
);

  lce_req_s  req;
  lce_resp_s resp;
  logic      req_v, req_ready, resp_v, resp_ready;
  logic      set_tag, set_tag_wakeup, cce_data, tr_data, uc_data;
  logic      req_pop, resp_pop;

  // the network side pops only a valid head
  assign req_pop  = lce_req_ready_i & lce_req_v_o;
  assign resp_pop = lce_resp_yumi_i & lce_resp_v_o;

  dcache_lce_req req_handler (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .lce_id_i                  (lce_id_i),
    .miss_i                    (miss_i),
    .cache_miss_o              (cache_miss_o),
    .miss_addr_o               (miss_addr_o),
    .set_tag_received_i        (set_tag),
    .set_tag_wakeup_received_i (set_tag_wakeup),
    .cce_data_received_i       (cce_data),
    .tr_data_received_i        (tr_data),
    .uncached_data_received_i  (uc_data),
    .req_o                     (req),
    .req_v_o                   (req_v),
    .req_ready_i               (req_ready),
    .resp_o                    (resp),
    .resp_v_o                  (resp_v),
    .resp_ready_i              (resp_ready)
  );

  dcache_lce_cmd cmd_handler (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .cmd_i                     (lce_cmd_i),
    .cmd_v_i                   (lce_cmd_v_i),
    .cmd_ready_o               (lce_cmd_ready_o),
    .set_tag_received_o        (set_tag),
    .set_tag_wakeup_received_o (set_tag_wakeup),
    .cce_data_received_o       (cce_data),
    .tr_data_received_o        (tr_data),
    .uncached_data_received_o  (uc_data),
    .fill_o                    (fill_o),
    .fill_v_o                  (fill_v_o),
    .tag_v_o                   (tag_v_o),
    .tag_way_o                 (tag_way_o),
    .tag_addr_o                (tag_addr_o)
  );

  lce_msg_queue #(.payload_t(lce_req_s)) req_queue (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (req),
    .v_i     (req_v),
    .ready_o (req_ready),
    .data_o  (lce_req_o),
    .v_o     (lce_req_v_o),
    .yumi_i  (req_pop)
  );

  lce_msg_queue #(.payload_t(lce_resp_s)) resp_queue (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (resp),
    .v_i     (resp_v),
    .ready_o (resp_ready),
    .data_o  (lce_resp_o),
    .v_o     (lce_resp_v_o),
    .yumi_i  (resp_pop)
  );

endmodule

/* testbench/tb_dcache_lce.sv */
`timescale 1ns/1ps
`include "lce_consts.svh"

module tb_dcache_lce
  import lce_msg_pkg::*, dcache_if_pkg::*;
();

  localparam int NUM_TXN        = 40;
  localparam int CYCLES_PER_TXN = 60;
  localparam int TIMEOUT_CYCLES = NUM_TXN * CYCLES_PER_TXN;

  localparam int KIND_LOAD     = 0;
  localparam int KIND_STORE    = 1;
  localparam int KIND_UC_LOAD  = 2;
  localparam int KIND_UC_STORE = 3;

  logic                         clk_i;
  logic                         reset_i;
  logic [`LCE_LCE_ID_WIDTH-1:0] lce_id_i;
  dcache_miss_s                 miss_i;
  logic                         cache_miss_o;
  logic [`LCE_PADDR_WIDTH-1:0]  miss_addr_o;
  lce_cmd_s                     lce_cmd_i;
  logic                         lce_cmd_v_i;
  logic                         lce_cmd_ready_o;
  lce_req_s                     lce_req_o;
  logic                         lce_req_v_o;
  logic                         lce_req_ready_i;
  lce_resp_s                    lce_resp_o;
  logic                         lce_resp_v_o;
  logic                         lce_resp_yumi_i;
  dcache_fill_s                 fill_o;
  logic                         fill_v_o;
  logic                         tag_v_o;
  logic [`LCE_WAY_ID_WIDTH-1:0] tag_way_o;
  logic [`LCE_PADDR_WIDTH-1:0]  tag_addr_o;

  // expected and observed messages, in network order
  lce_req_s  exp_req_q[$];
  lce_resp_s exp_resp_q[$];
  lce_req_s  obs_req_q[$];
  lce_resp_s obs_resp_q[$];

  int reqs_issued   = 0;
  int acks_expected = 0;
  int req_pop_cnt   = 0;
  int resp_pop_cnt  = 0;
  int cycle_count   = 0;

  dcache_lce dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .lce_id_i        (lce_id_i),
    .miss_i          (miss_i),
    .cache_miss_o    (cache_miss_o),
    .miss_addr_o     (miss_addr_o),
    .lce_cmd_i       (lce_cmd_i),
    .lce_cmd_v_i     (lce_cmd_v_i),
    .lce_cmd_ready_o (lce_cmd_ready_o),
    .lce_req_o       (lce_req_o),
    .lce_req_v_o     (lce_req_v_o),
    .lce_req_ready_i (lce_req_ready_i),
    .lce_resp_o      (lce_resp_o),
    .lce_resp_v_o    (lce_resp_v_o),
    .lce_resp_yumi_i (lce_resp_yumi_i),
    .fill_o          (fill_o),
    .fill_v_o        (fill_v_o),
    .tag_v_o         (tag_v_o),
    .tag_way_o       (tag_way_o),
    .tag_addr_o      (tag_addr_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("simulation timed out after %0d cycles", cycle_count));
    end
  end

  function automatic dcache_miss_s make_miss(input int kind);
    dcache_miss_s m;
    logic [31:0]  r;
    m                = '0;
    m.load_miss      = (kind == KIND_LOAD);
    m.store_miss     = (kind == KIND_STORE);
    m.uncached_load  = (kind == KIND_UC_LOAD);
    m.uncached_store = (kind == KIND_UC_STORE);
    r                = $urandom();
    m.addr           = r[`LCE_PADDR_WIDTH-1:0];
    r                = $urandom();
    m.lru_way        = r[`LCE_WAY_ID_WIDTH-1:0];
    m.dirty          = r[8 +: `LCE_WAYS];
    m.size           = r[20 +: 2];
    m.store_data     = {$urandom(), $urandom()};
    return m;
  endfunction

  // expected request for a miss with its home directory as destination
  function automatic lce_req_s expect_req(input dcache_miss_s m,
                                          input logic [`LCE_LCE_ID_WIDTH-1:0] id);
    lce_req_s e;
    e          = '0;
    e.dst_id   = m.addr[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_CCE_ID_WIDTH];
    e.src_id   = id;
    e.addr     = m.addr;
    e.msg_type = (m.load_miss || m.uncached_load) ? e_lce_req_rd : e_lce_req_wr;
    if (m.uncached_load || m.uncached_store) begin
      e.non_cacheable = e_lce_req_non_cacheable;
      e.nc_size       = lce_nc_size_e'(m.size);
      if (m.uncached_store) begin
        e.data = m.store_data;
      end
    end else begin
      e.non_cacheable = e_lce_req_cacheable;
      e.lru_way_id    = m.lru_way;
      e.lru_dirty     = m.dirty[m.lru_way];
    end
    return e;
  endfunction

  // transfer is answered by a transfer ack, cce data by a coherence ack
  function automatic lce_resp_s expect_ack(input logic [`LCE_PADDR_WIDTH-1:0] addr,
                                           input logic [`LCE_LCE_ID_WIDTH-1:0] id,
                                           input lce_cmd_type_e data_kind);
    lce_resp_s e;
    e.dst_id   = addr[`LCE_BLOCK_OFFSET_WIDTH +: `LCE_CCE_ID_WIDTH];
    e.src_id   = id;
    e.addr     = addr;
    e.msg_type = (data_kind == e_lce_cmd_transfer) ? e_lce_resp_tr_ack : e_lce_resp_coh_ack;
    return e;
  endfunction

  task automatic check_req(input lce_req_s got, input lce_req_s exp);
    assert (got.dst_id == exp.dst_id && got.src_id == exp.src_id)
      else stop_with_error($sformatf("FAIL %0t: request ids dst %0d src %0d, expected %0d %0d",
                                     $time, got.dst_id, got.src_id, exp.dst_id, exp.src_id));
    assert (got.msg_type == exp.msg_type && got.non_cacheable == exp.non_cacheable)
      else stop_with_error($sformatf("FAIL %0t: request kind %0d/%0d, expected %0d/%0d",
                                     $time, got.msg_type, got.non_cacheable,
                                     exp.msg_type, exp.non_cacheable));
    assert (got.addr == exp.addr)
      else stop_with_error($sformatf("FAIL %0t: request address %h, expected %h",
                                     $time, got.addr, exp.addr));
    if (exp.non_cacheable == e_lce_req_cacheable) begin
      assert (got.lru_way_id == exp.lru_way_id && got.lru_dirty == exp.lru_dirty)
        else stop_with_error($sformatf("FAIL %0t: lru way %0d dirty %0d, expected %0d %0d",
                                       $time, got.lru_way_id, got.lru_dirty,
                                       exp.lru_way_id, exp.lru_dirty));
    end else begin
      assert (got.nc_size == exp.nc_size)
        else stop_with_error($sformatf("FAIL %0t: uncached size %0d, expected %0d",
                                       $time, got.nc_size, exp.nc_size));
      if (exp.msg_type == e_lce_req_wr) begin
        assert (got.data == exp.data)
          else stop_with_error($sformatf("FAIL %0t: store data %h, expected %h",
                                         $time, got.data, exp.data));
      end
    end
  endtask

  // network model that applies random back-pressure and records every pop
  initial begin : network
    @(negedge reset_i);
    forever begin
      @(negedge clk_i);
      lce_req_ready_i = ($urandom_range(0, 9) < 7);
      lce_resp_yumi_i = ($urandom_range(0, 9) < 6);
      #1;
      if (lce_req_ready_i && lce_req_v_o) begin
        obs_req_q.push_back(lce_req_o);
        req_pop_cnt++;
      end
      if (lce_resp_yumi_i && lce_resp_v_o) begin
        obs_resp_q.push_back(lce_resp_o);
        resp_pop_cnt++;
      end
    end
  end

  initial begin : compare_messages
    lce_req_s  got_req;
    lce_resp_s got_resp;
    lce_resp_s exp_resp;
    @(negedge reset_i);
    forever begin
      @(negedge clk_i);
      #2;
      while (obs_req_q.size() > 0) begin
        got_req = obs_req_q.pop_front();
        assert (exp_req_q.size() > 0)
          else stop_with_error($sformatf("FAIL %0t: request %h with no miss outstanding",
                                         $time, got_req.addr));
        check_req(got_req, exp_req_q.pop_front());
      end
      while (obs_resp_q.size() > 0) begin
        got_resp = obs_resp_q.pop_front();
        assert (exp_resp_q.size() > 0)
          else stop_with_error($sformatf("FAIL %0t: unexpected ack %h", $time, got_resp));
        exp_resp = exp_resp_q.pop_front();
        assert (got_resp == exp_resp)
          else stop_with_error($sformatf("FAIL %0t: ack %h, expected %h",
                                         $time, got_resp, exp_resp));
      end
    end
  end

  // called at a falling edge, returns at the next one
  task automatic send_cmd(input lce_cmd_type_e kind, input logic [`LCE_PADDR_WIDTH-1:0] addr);
    lce_cmd_s     c;
    dcache_fill_s exp_fill;
    logic [31:0]  r;
    r          = $urandom();
    c.msg_type = kind;
    c.way_id   = r[`LCE_WAY_ID_WIDTH-1:0];
    c.addr     = addr;
    c.data     = {$urandom(), $urandom()};
    lce_cmd_i   = c;
    lce_cmd_v_i = 1'b1;
    assert (lce_cmd_ready_o)
      else stop_with_error($sformatf("FAIL %0t: lce_cmd_ready_o low for cmd %0d",
                                     $time, kind));
    @(negedge clk_i);
    lce_cmd_v_i = 1'b0;
    if (kind == e_lce_cmd_set_tag || kind == e_lce_cmd_set_tag_wakeup) begin
      assert (tag_v_o && !fill_v_o && tag_way_o == c.way_id && tag_addr_o == c.addr)
        else stop_with_error($sformatf("FAIL %0t: tag write v %0d way %0d addr %h for cmd %0d",
                                       $time, tag_v_o, tag_way_o, tag_addr_o, kind));
    end else begin
      exp_fill.way_id = c.way_id;
      exp_fill.addr   = c.addr;
      exp_fill.data   = c.data;
      assert (fill_v_o && !tag_v_o && fill_o == exp_fill)
        else stop_with_error($sformatf("FAIL %0t: fill v %0d %h, expected %h",
                                       $time, fill_v_o, fill_o, exp_fill));
    end
  endtask

  task automatic resolve_miss(input logic [`LCE_PADDR_WIDTH-1:0] addr);
    int            res;
    lce_cmd_type_e data_kind;
    res = $urandom_range(0, 2);
    if (res == 0) begin
      send_cmd(e_lce_cmd_set_tag_wakeup, addr);
    end else begin
      data_kind = (res == 1) ? e_lce_cmd_data : e_lce_cmd_transfer;
      exp_resp_q.push_back(expect_ack(addr, lce_id_i, data_kind));
      acks_expected++;
      // either order of the two commands
      if ($urandom_range(0, 1) == 1) begin
        send_cmd(e_lce_cmd_set_tag, addr);
        repeat ($urandom_range(0, 2)) @(negedge clk_i);
        send_cmd(data_kind, addr);
      end else begin
        send_cmd(data_kind, addr);
        repeat ($urandom_range(0, 2)) @(negedge clk_i);
        send_cmd(e_lce_cmd_set_tag, addr);
      end
    end
  endtask

  initial begin : stimulus
    int           kind;
    dcache_miss_s m;
    logic [31:0]  r;
    void'($urandom(32'h61364f21));
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    r               = $urandom();
    lce_id_i        = r[`LCE_LCE_ID_WIDTH-1:0];
    miss_i          = '0;
    lce_cmd_i       = '0;
    lce_cmd_v_i     = 1'b0;
    lce_req_ready_i = 1'b0;
    lce_resp_yumi_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;
    assert (!cache_miss_o && !fill_v_o && !tag_v_o && !lce_req_v_o && !lce_resp_v_o)
      else stop_with_error($sformatf("FAIL %0t: outputs not low after reset", $time));

    for (int t = 0; t < NUM_TXN; t++) begin
      @(negedge clk_i);
      kind = $urandom_range(0, 3);
      m    = make_miss(kind);
      exp_req_q.push_back(expect_req(m, lce_id_i));
      reqs_issued++;
      miss_i = m;
      #1;
      if (kind == KIND_UC_STORE) begin
        // pushed on the edge after cache_miss_o is seen low
        while (cache_miss_o) begin
          @(negedge clk_i);
          #1;
        end
        @(negedge clk_i);
        miss_i = '0;
      end else begin
        assert (cache_miss_o)
          else stop_with_error($sformatf("FAIL %0t: cache_miss_o low on a miss", $time));
        while (req_pop_cnt < reqs_issued) @(negedge clk_i);
        assert (miss_addr_o == m.addr)
          else stop_with_error($sformatf("FAIL %0t: miss address %h, expected %h",
                                         $time, miss_addr_o, m.addr));
        miss_i = '0;
        repeat ($urandom_range(0, 4)) @(negedge clk_i);
        if (kind == KIND_UC_LOAD) begin
          send_cmd(e_lce_cmd_uc_data, m.addr);
        end else begin
          resolve_miss(m.addr);
        end
        while (cache_miss_o) @(negedge clk_i);
      end
    end

    // let the queues drain, then look for stray messages
    while (exp_req_q.size() != 0 || exp_resp_q.size() != 0) @(negedge clk_i);
    repeat (10) @(negedge clk_i);
    if (req_pop_cnt == reqs_issued && resp_pop_cnt == acks_expected) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("message count mismatch: %0d requests for %0d misses, %0d acks for %0d",
               req_pop_cnt, reqs_issued, resp_pop_cnt, acks_expected);
      $display("Done: errors found");
      $fatal(1, "stopping on a message count mismatch");
    end
  end

endmodule

/* project.f */
+incdir+src
src/lce_msg_pkg.sv
src/dcache_if_pkg.sv
src/lce_msg_queue.sv
src/dcache_lce_req.sv
src/dcache_lce_cmd.sv
src/dcache_lce.sv
testbench/tb_dcache_lce.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the dcache LCE testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "could not create $BUILD_DIR"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_dcache_lce \
  -f project.f \
  --Mdir "$BUILD_DIR/obj_dir" -o tb_dcache_lce
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"$BUILD_DIR/obj_dir/tb_dcache_lce" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
